// ==== list.f ====
+incdir+rtl
rtl/idct_pkg.sv
rtl/block_ram_if.sv
rtl/dual_port_ram.sv
rtl/idct_control.sv
rtl/block_fetch.sv
rtl/matrix_mac.sv
rtl/pixel_writer.sv
rtl/idct_top.sv
sim/idct_properties.sv
sim/idct_tb.sv

// ==== sim/idct_tb.sv ====
// IDCT block decoder testbench
`timescale 1ns/10ps
`include "idct_config.svh"

module idct_tb
	import idct_pkg::*;
();
	localparam int CYCLE_LIMIT = 12 * 1500;
	localparam int RANDOM_BLOCKS = 8;

	logic Clock;
	logic Resetn;
	logic start_i;
	block_pos_t block_row_i;
	block_pos_t block_col_i;
	sram_word_t sram_read_data_i;
	sram_addr_t sram_address_o;
	sram_word_t sram_write_data_o;
	logic sram_we_n_o;
	logic done_o;

	sram_word_t sram_memory [sram_addr_t];
	sram_word_t read_pipe [2];
	sram_addr_t write_addresses [$];
	sram_word_t write_words [$];
	int done_count;
	int cycle_count;
	int data_errors;
	int address_errors;
	int protocol_errors;
	int unsigned lcg_state;
	block_pos_t current_row;
	block_pos_t current_col;
	int coef_block [8][8];
	pixel_t pixel_model [8][8];

	idct_top u_dut (
		.Clock(Clock),
		.Resetn(Resetn),
		.start_i(start_i),
		.block_row_i(block_row_i),
		.block_col_i(block_col_i),
		.sram_read_data_i(sram_read_data_i),
		.sram_address_o(sram_address_o),
		.sram_write_data_o(sram_write_data_o),
		.sram_we_n_o(sram_we_n_o),
		.done_o(done_o)
	);

	bind idct_top idct_properties u_properties (
		.Clock(Clock),
		.Resetn(Resetn),
		.done_o(done_o),
		.sram_we_n_o(sram_we_n_o),
		.sram_address_o(sram_address_o)
	);

	initial Clock = 1'b0;
	always #2 Clock = ~Clock;

	always @(posedge Clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: tests still running after %0d cycles", cycle_count);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic int unsigned next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// Unwritten words read back a pattern of the full address
	function automatic sram_word_t read_word(input sram_addr_t address);
		if (sram_memory.exists(address)) begin
			return sram_memory[address];
		end
		return address[15:0] ^ {14'd0, address[17:16]} ^ 16'hA5C3;
	endfunction

	// Coefficient word for row r and column c of a block
	function automatic sram_addr_t coef_address(input block_pos_t row, input block_pos_t col,
		input int r, input int c);
		return sram_addr_t'(`PRE_IDCT_BASE + (int'(row) * 8 + r) * `COEF_ROW_STRIDE
			+ int'(col) * 8 + c);
	endfunction

	task automatic check_read_address(input sram_addr_t address);
		int offset;
		if (address >= sram_addr_t'(`PRE_IDCT_BASE)) begin
			offset = int'(address) - `PRE_IDCT_BASE;
			if (offset / `COEF_ROW_STRIDE / 8 != int'(current_row)
				|| offset % `COEF_ROW_STRIDE / 8 != int'(current_col)) begin
				address_errors++;
				$display("Read at %0t from address %0d lies outside block (%0d, %0d)",
					$time, address, current_row, current_col);
			end
		end
	endtask

	// SRAM model, two-cycle read latency
	always @(posedge Clock) begin
		sram_addr_t address;
		address = sram_address_o;
		read_pipe[1] = read_pipe[0];
		if (!sram_we_n_o) begin
			sram_memory[address] = sram_write_data_o;
			write_addresses.push_back(address);
			write_words.push_back(sram_write_data_o);
			read_pipe[0] = '0;
		end else begin
			check_read_address(address);
			read_pipe[0] = read_word(address);
		end
		if (done_o) begin
			done_count++;
		end
		#1;
		sram_read_data_i = read_pipe[1];
	end

	task automatic compare_word(input string name, input sram_word_t actual,
		input sram_word_t expected);
		if (actual !== expected) begin
			data_errors++;
			$display("CHECK FAILED at %0t: %s = 0x%04h, expected 0x%04h",
				$time, name, actual, expected);
		end
	endtask

	task automatic compare_address(input string name, input sram_addr_t actual,
		input sram_addr_t expected);
		if (actual !== expected) begin
			address_errors++;
			$display("CHECK FAILED at %0t: %s = %0d, expected %0d",
				$time, name, actual, expected);
		end
	endtask

	// T = S' * C, then S = C' * T, clipped
	task automatic compute_model();
		int t_block [8][8];
		int sum;
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				sum = 0;
				for (int k = 0; k < 8; k++) begin
					sum += coef_block[r][k] * int'(cosine_value(3'(k), 3'(c)));
				end
				t_block[r][c] = sum >>> `PASS1_SHIFT;
			end
		end
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				sum = 0;
				for (int k = 0; k < 8; k++) begin
					sum += int'(cosine_value(3'(k), 3'(r))) * t_block[k][c];
				end
				sum = sum >>> `PASS2_SHIFT;
				pixel_model[r][c] = sum < 0 ? 8'd0 : (sum > 255 ? 8'd255 : 8'(sum));
			end
		end
	endtask

	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(posedge Clock);
			#1;
			if (sram_we_n_o !== 1'b1 || done_o !== 1'b0) begin
				protocol_errors++;
				$display("SRAM write or done_o seen at %0t before any start", $time);
			end
		end
	endtask

	task automatic run_block(input block_pos_t row, input block_pos_t col,
		input bit extra_start);
		sram_addr_t expected_address;
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				sram_memory[coef_address(row, col, r, c)] = sram_word_t'(coef_block[r][c]);
			end
		end
		compute_model();
		write_addresses.delete();
		write_words.delete();
		done_count = 0;
		current_row = row;
		current_col = col;
		block_row_i = row;
		block_col_i = col;
		start_i = 1'b1;
		@(posedge Clock);
		#1;
		start_i = 1'b0;
		if (extra_start) begin
			// Lands in the rows pass
			repeat (300) @(posedge Clock);
			#1;
			// Fetch is over, so only a refetch would see these words
			for (int r = 0; r < 8; r++) begin
				for (int c = 0; c < 8; c++) begin
					sram_memory[coef_address(row, col, r, c)] = sram_word_t'(~coef_block[r][c]);
				end
			end
			start_i = 1'b1;
			@(posedge Clock);
			#1;
			start_i = 1'b0;
		end
		while (done_count == 0) begin
			@(posedge Clock);
			#1;
		end
		// A queued second block would finish within the longer window
		repeat (extra_start ? 1300 : 4) @(posedge Clock);
		#1;
		if (done_count != 1) begin
			protocol_errors++;
			$display("Block (%0d, %0d) gave %0d done pulses", row, col, done_count);
		end
		if (write_addresses.size() != 32) begin
			protocol_errors++;
			$display("Block (%0d, %0d) made %0d SRAM writes instead of 32",
				row, col, write_addresses.size());
		end else begin
			for (int j = 0; j < 32; j++) begin
				expected_address = sram_addr_t'(`Y_BASE + (int'(row) * 8 + j / 4)
					* `PIXEL_ROW_STRIDE + int'(col) * 4 + j % 4);
				compare_address($sformatf("sram_address_o[%0d]", j),
					write_addresses[j], expected_address);
				compare_word($sformatf("sram_write_data_o[%0d]", j), write_words[j],
					{pixel_model[j / 4][2 * (j % 4)], pixel_model[j / 4][2 * (j % 4) + 1]});
			end
		end
	endtask

	task automatic fill_random();
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				coef_block[r][c] = int'(next_random() % 128) - 64;
			end
		end
	endtask

	task automatic fill_dc(input int value);
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				coef_block[r][c] = 0;
			end
		end
		coef_block[0][0] = value;
	endtask

	task automatic check_uniform(input sram_word_t value);
		foreach (write_words[j]) begin
			compare_word($sformatf("sram_write_data_o[%0d]", j), write_words[j], value);
		end
	endtask

	initial begin
		int total_errors;
		lcg_state = 32'd95411;
		Resetn = 1'b0;
		start_i = 1'b0;
		block_row_i = '0;
		block_col_i = '0;
		sram_read_data_i = '0;
		read_pipe[0] = '0;
		read_pipe[1] = '0;
		done_count = 0;
		cycle_count = 0;
		data_errors = 0;
		address_errors = 0;
		protocol_errors = 0;
		current_row = '0;
		current_col = '0;
		repeat (2) @(posedge Clock);
		#1;
		Resetn = 1'b1;
		check_idle(20);

		for (int b = 0; b < RANDOM_BLOCKS; b++) begin
			fill_random();
			run_block(block_pos_t'(next_random() % 30), block_pos_t'(next_random() % 40), 1'b0);
		end

		// Saturation at both ends
		fill_dc(4000);
		run_block(6'd3, 6'd17, 1'b0);
		check_uniform(16'hFFFF);
		fill_dc(-4000);
		run_block(6'd29, 6'd39, 1'b0);
		check_uniform(16'h0000);

		fill_random();
		run_block(block_pos_t'(next_random() % 30), block_pos_t'(next_random() % 40), 1'b1);

		total_errors = data_errors + address_errors + protocol_errors
			+ int'(u_dut.u_properties.assertion_failures);
		$display("Errors: %0d data, %0d address, %0d protocol, %0d assertion",
			data_errors, address_errors, protocol_errors,
			u_dut.u_properties.assertion_failures);
		if (total_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end
endmodule

// ==== sim/idct_properties.sv ====
// IDCT SRAM port checks
`timescale 1ns/10ps
`include "idct_config.svh"

module idct_properties
	import idct_pkg::*;
(
	input logic Clock,
	input logic Resetn,
	input logic done_o,
	input logic sram_we_n_o,
	input sram_addr_t sram_address_o
);
	// Read by the testbench at the end of the run
	int unsigned assertion_failures = 0;

	done_single_pulse: assert property (@(posedge Clock) disable iff (!Resetn)
		done_o |=> !done_o)
		else begin
			assertion_failures++;
			$error("done_o stayed high for two cycles");
		end

	// Writes only land in the Y region
	write_below_coefficients: assert property (@(posedge Clock) disable iff (!Resetn)
		!sram_we_n_o |-> sram_address_o < sram_addr_t'(`PRE_IDCT_BASE))
		else begin
			assertion_failures++;
			$error("SRAM write at address %0d inside the coefficient region", sram_address_o);
		end

	quiet_after_done: assert property (@(posedge Clock) disable iff (!Resetn)
		done_o |=> sram_we_n_o)
		else begin
			assertion_failures++;
			$error("SRAM write in the cycle after done_o");
		end
endmodule

// ==== rtl/idct_top.sv ====
// 8x8 IDCT block decoder
`timescale 1ns/10ps
`include "idct_config.svh"

module idct_top
	import idct_pkg::*;
(
	input logic Clock,
	input logic Resetn,
	input logic start_i,
	input block_pos_t block_row_i,
	input block_pos_t block_col_i,
	input sram_word_t sram_read_data_i,
	output sram_addr_t sram_address_o,
	output sram_word_t sram_write_data_o,
	output logic sram_we_n_o,
	output logic done_o
);
	logic fetch_go;
	logic fetch_done;
	logic rows_go;
	logic rows_done;
	logic cols_go;
	logic cols_done;
	logic write_go;
	logic write_done;
	sram_addr_t fetch_address;
	sram_addr_t writer_address;
	sram_word_t writer_data;
	logic writer_we;

	// S', T and S, each with one producer and one consumer
	block_ram_if ram_s_prime ();
	block_ram_if ram_t ();
	block_ram_if ram_s ();

	idct_control u_control (
		.Clock(Clock),
		.Resetn(Resetn),
		.start_i(start_i),
		.fetch_go_o(fetch_go),
		.fetch_done_i(fetch_done),
		.rows_go_o(rows_go),
		.rows_done_i(rows_done),
		.cols_go_o(cols_go),
		.cols_done_i(cols_done),
		.write_go_o(write_go),
		.write_done_i(write_done),
		.fetch_address_i(fetch_address),
		.writer_address_i(writer_address),
		.writer_data_i(writer_data),
		.writer_we_i(writer_we),
		.sram_address_o(sram_address_o),
		.sram_write_data_o(sram_write_data_o),
		.sram_we_n_o(sram_we_n_o),
		.done_o(done_o)
	);

	block_fetch u_fetch (
		.Clock(Clock),
		.Resetn(Resetn),
		.go_i(fetch_go),
		.block_row_i(block_row_i),
		.block_col_i(block_col_i),
		.sram_read_data_i(sram_read_data_i),
		.fetch_address_o(fetch_address),
		.done_o(fetch_done),
		.ram_port(ram_s_prime)
	);

	matrix_mac #(.ROW_PASS(1'b1), .SHIFT(`PASS1_SHIFT)) u_rows (
		.Clock(Clock),
		.Resetn(Resetn),
		.go_i(rows_go),
		.done_o(rows_done),
		.source(ram_s_prime),
		.sink(ram_t)
	);

	matrix_mac #(.ROW_PASS(1'b0), .SHIFT(`PASS2_SHIFT)) u_cols (
		.Clock(Clock),
		.Resetn(Resetn),
		.go_i(cols_go),
		.done_o(cols_done),
		.source(ram_t),
		.sink(ram_s)
	);

	pixel_writer u_writer (
		.Clock(Clock),
		.Resetn(Resetn),
		.go_i(write_go),
		.block_row_i(block_row_i),
		.block_col_i(block_col_i),
		.writer_address_o(writer_address),
		.writer_data_o(writer_data),
		.writer_we_o(writer_we),
		.done_o(write_done),
		.ram_port(ram_s)
	);

	dual_port_ram u_ram_s_prime (.Clock(Clock), .ram_port(ram_s_prime));
	dual_port_ram u_ram_t (.Clock(Clock), .ram_port(ram_t));
	dual_port_ram u_ram_s (.Clock(Clock), .ram_port(ram_s));
endmodule

// ==== rtl/pixel_writer.sv ====
// Pixel clip, pack and SRAM write
`timescale 1ns/10ps
`include "idct_config.svh"

module pixel_writer
	import idct_pkg::*;
(
	input logic Clock,
	input logic Resetn,
	input logic go_i,
	input block_pos_t block_row_i,
	input block_pos_t block_col_i,
	output sram_addr_t writer_address_o,
	output sram_word_t writer_data_o,
	output logic writer_we_o,
	output logic done_o,
	block_ram_if.consumer ram_port
);
	block_pos_t block_row;
	block_pos_t block_col;
	ram_addr_t read_index;
	logic reading;
	ram_addr_t data_index;
	logic data_valid;
	pixel_t even_pixel;
	pixel_t clipped;

	function automatic pixel_t clip_pixel(input acc_t value);
		pixel_t result;
		if (value < 0) begin
			result = 8'd0;
		end else if (value > 255) begin
			result = 8'd255;
		end else begin
			result = value[7:0];
		end
		return result;
	endfunction

	assign ram_port.read_address = read_index;
	assign clipped = clip_pixel(ram_port.read_data);

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			reading <= 1'b0;
			read_index <= '0;
			data_valid <= 1'b0;
			writer_we_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			if (go_i) begin
				reading <= 1'b1;
				read_index <= '0;
			end else if (reading) begin
				read_index <= read_index + 6'd1;
				if (read_index == ram_addr_t'(`RAM_DEPTH - 1)) begin
					reading <= 1'b0;
				end
			end
			data_valid <= reading;
			// One word per pixel pair, written on the odd column
			writer_we_o <= data_valid && data_index[0];
			done_o <= data_valid && data_index == ram_addr_t'(`RAM_DEPTH - 1);
		end
	end

	always_ff @(posedge Clock) begin
		if (go_i) begin
			block_row <= block_row_i;
			block_col <= block_col_i;
		end
		data_index <= read_index;
		if (!data_index[0]) begin
			even_pixel <= clipped;
		end
		// Even column in the upper byte
		writer_data_o <= {even_pixel, clipped};
		writer_address_o <= sram_addr_t'(`Y_BASE)
			+ sram_addr_t'({block_row, data_index[5:3]}) * sram_addr_t'(`PIXEL_ROW_STRIDE)
			+ sram_addr_t'({block_col, data_index[2:1]});
	end
endmodule

// ==== rtl/matrix_mac.sv ====
// One matrix product pass of the IDCT
`timescale 1ns/10ps

module matrix_mac
	import idct_pkg::*;
#(
	parameter bit ROW_PASS = 1'b1,
	parameter int SHIFT = 8
)
(
	input logic Clock,
	input logic Resetn,
	input logic go_i,
	output logic done_o,
	block_ram_if.consumer source,
	block_ram_if.producer sink
);
	// Output index in [8:3], product term in [2:0]
	logic [8:0] issue_count;
	logic issuing;
	logic [8:0] data_count;
	logic data_valid;
	logic [2:0] term;
	logic [2:0] sample;
	acc_t operand_even;
	acc_t accumulator;
	acc_t product_even;
	acc_t product_odd;
	acc_t total;
	cos_t cos_even;
	cos_t cos_odd;

	// Rows pass reads in[r][k], columns pass reads in[k][c]
	assign source.read_address = ROW_PASS ? {issue_count[8:6], issue_count[2:0]}
		: {issue_count[2:0], issue_count[5:3]};

	assign term = data_count[2:0];
	assign sample = ROW_PASS ? data_count[5:3] : data_count[8:6];

	// Two multipliers fire on every odd term
	assign cos_even = cosine_value({term[2:1], 1'b0}, sample);
	assign cos_odd = cosine_value(term, sample);
	assign product_even = operand_even * cos_even;
	assign product_odd = source.read_data * cos_odd;
	assign total = (term == 3'd1 ? acc_t'(0) : accumulator) + product_even + product_odd;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			issuing <= 1'b0;
			issue_count <= '0;
			data_valid <= 1'b0;
			sink.write_enable <= 1'b0;
			done_o <= 1'b0;
		end else begin
			if (go_i) begin
				issuing <= 1'b1;
				issue_count <= '0;
			end else if (issuing) begin
				issue_count <= issue_count + 9'd1;
				if (&issue_count) begin
					issuing <= 1'b0;
				end
			end
			data_valid <= issuing;
			sink.write_enable <= data_valid && term == 3'd7;
			done_o <= data_valid && &data_count;
		end
	end

	always_ff @(posedge Clock) begin
		data_count <= issue_count;
		if (!term[0]) begin
			operand_even <= source.read_data;
		end else begin
			accumulator <= total;
		end
		sink.write_address <= data_count[8:3];
		sink.write_data <= total >>> SHIFT;
	end
endmodule

// ==== rtl/block_fetch.sv ====
// Coefficient block fetch
`timescale 1ns/10ps
`include "idct_config.svh"

module block_fetch
	import idct_pkg::*;
(
	input logic Clock,
	input logic Resetn,
	input logic go_i,
	input block_pos_t block_row_i,
	input block_pos_t block_col_i,
	input sram_word_t sram_read_data_i,
	output sram_addr_t fetch_address_o,
	output logic done_o,
	block_ram_if.producer ram_port
);
	// Port register in control plus two SRAM cycles
	localparam int LATENCY = 3;

	block_pos_t block_row;
	block_pos_t block_col;
	ram_addr_t index;
	logic active;
	ram_addr_t index_pipe [LATENCY];
	logic [LATENCY-1:0] valid_pipe;
	coef_t coefficient;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			active <= 1'b0;
			index <= '0;
			valid_pipe <= '0;
		end else begin
			if (go_i) begin
				active <= 1'b1;
				index <= '0;
			end else if (active) begin
				index <= index + 6'd1;
				if (index == ram_addr_t'(`RAM_DEPTH - 1)) begin
					active <= 1'b0;
				end
			end
			valid_pipe <= {valid_pipe[LATENCY-2:0], active};
		end
	end

	always_ff @(posedge Clock) begin
		if (go_i) begin
			block_row <= block_row_i;
			block_col <= block_col_i;
		end
		index_pipe[0] <= index;
		for (int i = 1; i < LATENCY; i++) begin
			index_pipe[i] <= index_pipe[i-1];
		end
	end

	// Row r and column c of the block, row-major index
	assign fetch_address_o = sram_addr_t'(`PRE_IDCT_BASE)
		+ sram_addr_t'({block_row, index[5:3]}) * sram_addr_t'(`COEF_ROW_STRIDE)
		+ sram_addr_t'({block_col, index[2:0]});

	assign coefficient = sram_read_data_i;
	assign ram_port.write_enable = valid_pipe[LATENCY-1];
	assign ram_port.write_address = index_pipe[LATENCY-1];
	assign ram_port.write_data = acc_t'(coefficient);

	assign done_o = valid_pipe[LATENCY-1]
		&& index_pipe[LATENCY-1] == ram_addr_t'(`RAM_DEPTH - 1);
endmodule

// ==== rtl/idct_control.sv ====
// IDCT phase controller
`timescale 1ns/10ps

module idct_control
	import idct_pkg::*;
(
	input logic Clock,
	input logic Resetn,
	input logic start_i,
	output logic fetch_go_o,
	input logic fetch_done_i,
	output logic rows_go_o,
	input logic rows_done_i,
	output logic cols_go_o,
	input logic cols_done_i,
	output logic write_go_o,
	input logic write_done_i,
	input sram_addr_t fetch_address_i,
	input sram_addr_t writer_address_i,
	input sram_word_t writer_data_i,
	input logic writer_we_i,
	output sram_addr_t sram_address_o,
	output sram_word_t sram_write_data_o,
	output logic sram_we_n_o,
	output logic done_o
);
	idct_phase_t phase;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			phase <= PHASE_IDLE;
			fetch_go_o <= 1'b0;
			rows_go_o <= 1'b0;
			cols_go_o <= 1'b0;
			write_go_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			fetch_go_o <= 1'b0;
			rows_go_o <= 1'b0;
			cols_go_o <= 1'b0;
			write_go_o <= 1'b0;
			done_o <= 1'b0;
			case (phase)
				PHASE_IDLE: begin
					// Start is ignored anywhere else
					if (start_i) begin
						fetch_go_o <= 1'b1;
						phase <= PHASE_FETCH;
					end
				end
				PHASE_FETCH: begin
					if (fetch_done_i) begin
						rows_go_o <= 1'b1;
						phase <= PHASE_ROWS;
					end
				end
				PHASE_ROWS: begin
					if (rows_done_i) begin
						cols_go_o <= 1'b1;
						phase <= PHASE_COLS;
					end
				end
				PHASE_COLS: begin
					if (cols_done_i) begin
						write_go_o <= 1'b1;
						phase <= PHASE_WRITE;
					end
				end
				PHASE_WRITE: begin
					if (write_done_i) begin
						phase <= PHASE_DONE;
					end
				end
				PHASE_DONE: begin
					done_o <= 1'b1;
					phase <= PHASE_IDLE;
				end
				default: begin
					phase <= PHASE_IDLE;
				end
			endcase
		end
	end

	// SRAM port, owned by fetch or writer depending on phase
	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			sram_address_o <= '0;
			sram_write_data_o <= '0;
			sram_we_n_o <= 1'b1;
		end else begin
			sram_we_n_o <= !(phase == PHASE_WRITE && writer_we_i);
			if (phase == PHASE_WRITE && writer_we_i) begin
				sram_address_o <= writer_address_i;
				sram_write_data_o <= writer_data_i;
			end else if (phase == PHASE_FETCH && !fetch_go_o) begin
				// Fetch address settles once the block position is latched
				sram_address_o <= fetch_address_i;
			end
		end
	end
endmodule

// ==== rtl/dual_port_ram.sv ====
// Block RAM with separate read and write ports
`timescale 1ns/10ps
`include "idct_config.svh"

module dual_port_ram
	import idct_pkg::*;
(
	input logic Clock,
	block_ram_if.ram ram_port
);
	acc_t memory [`RAM_DEPTH];

	always_ff @(posedge Clock) begin
		if (ram_port.write_enable) begin
			memory[ram_port.write_address] <= ram_port.write_data;
		end
	end

	// Read data valid one cycle after the address
	always_ff @(posedge Clock) begin
		ram_port.read_data <= memory[ram_port.read_address];
	end
endmodule

// ==== rtl/block_ram_if.sv ====
// On-chip RAM port bundle
`timescale 1ns/10ps

interface block_ram_if
	import idct_pkg::*;
();
	ram_addr_t write_address;
	acc_t write_data;
	logic write_enable;
	ram_addr_t read_address;
	acc_t read_data;

	modport producer (
		output write_address,
		output write_data,
		output write_enable
	);

	modport consumer (
		output read_address,
		input read_data
	);

	modport ram (
		input write_address,
		input write_data,
		input write_enable,
		input read_address,
		output read_data
	);
endinterface

// ==== rtl/idct_pkg.sv ====
// IDCT shared types
package idct_pkg;

	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_word_t;
	typedef logic signed [15:0] coef_t;
	typedef logic signed [12:0] cos_t;
	typedef logic signed [31:0] acc_t;
	typedef logic [5:0] ram_addr_t;
	typedef logic [7:0] pixel_t;
	typedef logic [5:0] block_pos_t;

	typedef enum logic [2:0] {
		PHASE_IDLE,
		PHASE_FETCH,
		PHASE_ROWS,
		PHASE_COLS,
		PHASE_WRITE,
		PHASE_DONE
	} idct_phase_t;

	// Scaled cosine for basis k at sample n
	function automatic cos_t cosine_value(input logic [2:0] k, input logic [2:0] n);
		logic [4:0] angle;
		logic [2:0] step;
		logic negative;
		cos_t magnitude;
		// Angle in units of pi/16, taken modulo 2*pi
		angle = 5'((2 * n + 1) * k);
		step = angle[3] ? 3'(4'd8 - {1'b0, angle[2:0]}) : angle[2:0];
		negative = angle[4] ^ angle[3];
		case (step)
			3'd0: magnitude = 13'sd1448;
			3'd1: magnitude = 13'sd2008;
			3'd2: magnitude = 13'sd1892;
			3'd3: magnitude = 13'sd1702;
			3'd4: magnitude = 13'sd1448;
			3'd5: magnitude = 13'sd1137;
			3'd6: magnitude = 13'sd783;
			default: magnitude = 13'sd399;
		endcase
		return negative ? -magnitude : magnitude;
	endfunction

endpackage

// ==== rtl/idct_config.svh ====
// IDCT configuration macros
`ifndef IDCT_CONFIG_SVH
`define IDCT_CONFIG_SVH

// Frame geometry
`define FRAME_WIDTH 320

// SRAM regions, in 16-bit words
`define PRE_IDCT_BASE 76800
`define Y_BASE 0

// One coefficient per word, two pixels per word
`define COEF_ROW_STRIDE (`FRAME_WIDTH)
`define PIXEL_ROW_STRIDE (`FRAME_WIDTH / 2)

// On-chip block RAM
`define RAM_DEPTH 64

// Scaling after each pass
`define PASS1_SHIFT 8
`define PASS2_SHIFT 16

`endif
